/* src/rv_types_pkg.sv */
package rv_types_pkg;

  // ####################
  // widths
  // ####################

  typedef logic [31:0] word_t;     // data or address word.
  typedef logic [4:0]  reg_idx_t;  // register file index.
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  localparam word_t ILEN_BYTES = 32'd4;  // no compressed instructions.

  // ####################
  // opcodes
  // ####################

  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;

  localparam funct3_t F3_FENCE_I = 3'b001;  // plain fence is 000.

  // ####################
  // control encodings
  // ####################

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,  // branch compares.
    ALU_PASS_B  // lui.
  } alu_op_t;

  typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} npc_sel_t;

  typedef enum logic [1:0] {WDATA_ALU, WDATA_LINK, WDATA_PC_IMM} wdata_sel_t;

endpackage

/* src/rv_stage_pkg.sv */
package rv_stage_pkg;

  // ####################
  // decode to execute
  // ####################

  typedef struct packed {
    logic                     valid;
    logic                     fence_i;
    rv_types_pkg::word_t      pc;
    rv_types_pkg::word_t      imm;
    rv_types_pkg::alu_op_t    alu_op;
    logic                     op1_fwd;    // rs1 from previous result.
    logic                     op2_fwd;    // rs2 from previous result.
    logic                     op1_pc;     // auipc.
    logic                     op2_imm;
    rv_types_pkg::npc_sel_t   npc_sel;
    rv_types_pkg::wdata_sel_t wdata_sel;
    logic                     writes_rd;
  } decode_t;

  // ####################
  // execute to result
  // ####################

  typedef struct packed {
    logic                     valid;
    logic                     fence_i;
    rv_types_pkg::word_t      alu_result;  // from registered operands.
    rv_types_pkg::word_t      snpc;
    rv_types_pkg::word_t      dnpc;
    rv_types_pkg::npc_sel_t   npc_sel;
    rv_types_pkg::wdata_sel_t wdata_sel;
  } exec_t;

endpackage

/* src/int_alu.sv */
`timescale 1ns/10ps

module int_alu (
  input  rv_types_pkg::alu_op_t op,
  input  rv_types_pkg::word_t   a,
  input  rv_types_pkg::word_t   b,
  output rv_types_pkg::word_t   result
);
  import rv_types_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    case (op)
      ALU_ADD:           result = a + b;
      ALU_SUB:           result = a - b;
      ALU_SLL:           result = a << shamt;
      ALU_SLT, ALU_LT:   result = {31'b0, lt_s};
      ALU_SLTU, ALU_LTU: result = {31'b0, lt_u};
      ALU_XOR:           result = a ^ b;
      ALU_SRL:           result = a >> shamt;
      ALU_SRA:           result = word_t'($signed(a) >>> shamt);
      ALU_OR:            result = a | b;
      ALU_AND:           result = a & b;
      ALU_EQ:            result = {31'b0, eq};   // bit 0 decides the branch.
      ALU_NE:            result = {31'b0, !eq};
      ALU_GE:            result = {31'b0, !lt_s};
      ALU_GEU:           result = {31'b0, !lt_u};
      ALU_PASS_B:        result = b;
      default:           result = '0;
    endcase
  end

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   block,
  input  logic                   instr_valid,
  input  rv_types_pkg::word_t    instr,
  input  rv_types_pkg::word_t    pc,
  input  logic                   squash,
  output rv_stage_pkg::decode_t  dec,
  output rv_types_pkg::reg_idx_t rd
);
  import rv_types_pkg::*;

  opcode_t  opcode;
  funct3_t  funct3;
  logic     funct7_5;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd_field;
  logic     uses_rs1;
  logic     uses_rs2;
  logic     accept;
  reg_idx_t last_rd;
  logic     last_write;

  function automatic alu_op_t alu_op_of(input funct3_t f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = instr[6:0];
  assign rd_field = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign funct7_5 = instr[30];

  always_comb begin
    dec           = '0;
    dec.valid     = instr_valid && !squash;  // slot after a redirect is dropped.
    dec.pc        = pc;
    dec.alu_op    = ALU_ADD;
    dec.npc_sel   = NPC_SEQ;
    dec.wdata_sel = WDATA_ALU;
    uses_rs1      = 1'b0;
    uses_rs2      = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec.alu_op    = alu_op_of(funct3, funct7_5);
        dec.writes_rd = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.alu_op    = alu_op_of(funct3, (funct3 == 3'b101) && funct7_5);  // only srai.
        dec.imm       = {{20{instr[31]}}, instr[31:20]};
        dec.op2_imm   = 1'b1;
        dec.writes_rd = 1'b1;
        uses_rs1      = 1'b1;
      end
      OPC_LUI: begin
        dec.alu_op    = ALU_PASS_B;
        dec.imm       = {instr[31:12], 12'b0};
        dec.op2_imm   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm       = {instr[31:12], 12'b0};
        dec.op1_pc    = 1'b1;
        dec.op2_imm   = 1'b1;
        dec.wdata_sel = WDATA_PC_IMM;
        dec.writes_rd = 1'b1;
      end
      OPC_JAL: begin
        dec.imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        dec.npc_sel   = NPC_JAL;
        dec.wdata_sel = WDATA_LINK;
        dec.writes_rd = 1'b1;
      end
      OPC_JALR: begin
        dec.imm       = {{20{instr[31]}}, instr[31:20]};
        dec.op2_imm   = 1'b1;
        dec.npc_sel   = NPC_JALR;
        dec.wdata_sel = WDATA_LINK;
        dec.writes_rd = 1'b1;
        uses_rs1      = 1'b1;
      end
      OPC_BRANCH: begin
        dec.imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.npc_sel = NPC_BRANCH;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        case (funct3)
          3'b001:  dec.alu_op = ALU_NE;
          3'b100:  dec.alu_op = ALU_LT;
          3'b101:  dec.alu_op = ALU_GE;
          3'b110:  dec.alu_op = ALU_LTU;
          3'b111:  dec.alu_op = ALU_GEU;
          default: dec.alu_op = ALU_EQ;
        endcase
      end
      OPC_MISC_MEM: dec.fence_i = (funct3 == F3_FENCE_I);
      default: ;  // unsupported opcodes retire as nop.
    endcase
    dec.op1_fwd = uses_rs1 && last_write && (last_rd == rs1);
    dec.op2_fwd = uses_rs2 && last_write && (last_rd == rs2);
  end

  // ####################
  // forward tracking
  // ####################

  assign accept = dec.valid && !block;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_write <= 1'b0;
    end else if (accept) begin
      last_write <= dec.writes_rd && (rd_field != '0);  // x0 never forwards.
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      last_rd <= rd_field;
    end
  end

  assign rd = last_rd;  // follows the instruction now in execute.

  // reads of x0 always see the register file value.
  a_no_x0_fwd: assert property (@(posedge clock) disable iff (reset)
    dec.valid |-> !(dec.op1_fwd && (rs1 == '0)) && !(dec.op2_fwd && (rs2 == '0)));

endmodule

/* src/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  block,
  input  rv_stage_pkg::decode_t dec,
  input  rv_types_pkg::word_t   src1,
  input  rv_types_pkg::word_t   src2,
  input  rv_types_pkg::word_t   fwd_data,
  output rv_stage_pkg::exec_t   ex,
  output logic                  rd_write
);
  import rv_types_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      operand1;
  word_t      operand2;
  word_t      snpc;
  word_t      dnpc;
  word_t      alu_result;
  alu_op_t    alu_op;
  npc_sel_t   npc_sel;
  wdata_sel_t wdata_sel;
  logic       valid;
  logic       fence_i;

  // ####################
  // operand select
  // ####################

  assign op_a = dec.op1_pc ? dec.pc : (dec.op1_fwd ? fwd_data : src1);
  assign op_b = dec.op2_imm ? dec.imm : (dec.op2_fwd ? fwd_data : src2);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= 1'b0;
      rd_write <= 1'b0;
    end else if (!block) begin
      valid    <= dec.valid;
      rd_write <= dec.valid && dec.writes_rd;
    end
  end

  // payload keeps the last accepted instruction so its result stays forwardable.
  always_ff @(posedge clock) begin
    if (!block && dec.valid) begin
      operand1  <= op_a;
      operand2  <= op_b;
      alu_op    <= dec.alu_op;
      snpc      <= dec.pc + ILEN_BYTES;
      dnpc      <= dec.pc + dec.imm;  // jal, branch and auipc target.
      npc_sel   <= dec.npc_sel;
      wdata_sel <= dec.wdata_sel;
      fence_i   <= dec.fence_i;
    end
  end

  // ####################
  // alu
  // ####################

  int_alu i_alu (
    .op     (alu_op),
    .a      (operand1),
    .b      (operand2),
    .result (alu_result)
  );

  always_comb begin
    ex.valid      = valid;
    ex.fence_i    = fence_i;
    ex.alu_result = alu_result;
    ex.snpc       = snpc;
    ex.dnpc       = dnpc;
    ex.npc_sel    = npc_sel;
    ex.wdata_sel  = wdata_sel;
  end

endmodule

/* src/result_select.sv */
`timescale 1ns/10ps

module result_select (
  input  logic                clock,
  input  logic                reset,
  input  logic                block,
  input  rv_stage_pkg::exec_t ex,
  output rv_types_pkg::word_t npc,
  output rv_types_pkg::word_t wdata,
  output logic                result_valid,
  output logic                clear_pipeline,
  output logic                clear_cache,
  output logic                squash
);
  import rv_types_pkg::*;

  always_comb begin
    case (ex.npc_sel)
      NPC_JAL:    npc = ex.dnpc;
      NPC_JALR:   npc = {ex.alu_result[31:1], 1'b0};
      NPC_BRANCH: npc = ex.alu_result[0] ? ex.dnpc : ex.snpc;  // compare bit.
      default:    npc = ex.snpc;
    endcase
  end

  always_comb begin
    case (ex.wdata_sel)
      WDATA_LINK:   wdata = ex.snpc;  // jal, jalr.
      WDATA_PC_IMM: wdata = ex.dnpc;  // auipc.
      default:      wdata = ex.alu_result;
    endcase
  end

  // ####################
  // redirect
  // ####################

  assign result_valid   = ex.valid;
  assign clear_cache    = ex.valid && ex.fence_i;
  assign clear_pipeline = (ex.valid && (npc != ex.snpc)) || clear_cache;
  assign squash         = clear_pipeline;  // drops the slot decoded this cycle.

  // the slot behind a redirect never produces a result.
  a_squash_drops: assert property (@(posedge clock) disable iff (reset)
    clear_pipeline && !block |=> !result_valid);

  // execute holds its registers, so a blocked cycle repeats the same result.
  a_block_holds: assert property (@(posedge clock) disable iff (reset)
    block |=> $stable(npc) && $stable(wdata) && $stable(result_valid));

endmodule

/* src/exec_top.sv */
`timescale 1ns/10ps

module exec_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   block,
  input  logic                   instr_valid,
  input  rv_types_pkg::word_t    instr,
  input  rv_types_pkg::word_t    pc,
  input  rv_types_pkg::word_t    src1,
  input  rv_types_pkg::word_t    src2,
  output logic                   result_valid,
  output rv_types_pkg::word_t    npc,
  output rv_types_pkg::word_t    wdata,
  output rv_types_pkg::reg_idx_t rd,
  output logic                   rd_write,
  output logic                   clear_pipeline,
  output logic                   clear_cache
);
  import rv_stage_pkg::*;

  decode_t dec;
  exec_t   ex;
  logic    squash;

  instr_decoder i_decoder (
    .clock       (clock),
    .reset       (reset),
    .block       (block),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .squash      (squash),
    .dec         (dec),
    .rd          (rd)
  );

  execute_stage i_execute (
    .clock    (clock),
    .reset    (reset),
    .block    (block),
    .dec      (dec),
    .src1     (src1),
    .src2     (src2),
    .fwd_data (wdata),  // previous result.
    .ex       (ex),
    .rd_write (rd_write)
  );

  result_select i_result (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .ex             (ex),
    .npc            (npc),
    .wdata          (wdata),
    .result_valid   (result_valid),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .squash         (squash)
  );

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
  output logic clock,
  output logic reset
);
  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 5;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;  // released just after the edge, like the other inputs.
  end

endmodule

/* tb/exec_top_tb.sv */
`timescale 1ns/10ps

module exec_top_tb;
  import rv_types_pkg::*;

  localparam logic [31:0] SEED  = 32'h21f9_6b69;
  localparam logic [7:0] VLD     = 8'h01;  // instr_valid.
  localparam logic [7:0] BLK     = 8'h02;  // block.
  localparam logic [7:0] RND1    = 8'h04;  // src1 is filler.
  localparam logic [7:0] RND2    = 8'h08;  // src2 is filler.
  localparam logic [7:0] EXP_V   = 8'h10;
  localparam logic [7:0] EXP_CLR = 8'h20;
  localparam logic [7:0] EXP_CC  = 8'h40;
  localparam logic [7:0] SKIP_W  = 8'h80;  // wdata has no meaning.
  localparam logic [7:0] RUN     = VLD | EXP_V;
  localparam logic [7:0] RNDS    = RND1 | RND2;

  typedef struct packed {
    word_t      instr;
    word_t      pc;
    word_t      src1;
    word_t      src2;
    logic [7:0] flags;
    word_t      npc;    // expected in the next cycle.
    word_t      wdata;
    int         group;
  } row_t;

  logic     clock;
  logic     reset;
  logic     block;
  logic     instr_valid;
  word_t    instr;
  word_t    pc;
  word_t    src1;
  word_t    src2;
  logic     result_valid;
  word_t    npc;
  word_t    wdata;
  reg_idx_t rd;
  logic     rd_write;
  logic     clear_pipeline;
  logic     clear_cache;

  row_t  rows[$];
  word_t shown_instr;  // instruction whose result is on the outputs.
  int    cur_group;
  int    group_checks;
  int    group_errors;
  int    total_checks;
  int    total_errors;
  int    cycle_count;
  int    cycle_limit;
  string group_name[6] = '{"reset", "alu", "branch/jump/squash", "forward", "block", "fence_i"};

  clock_gen i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  exec_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .src1           (src1),
    .src2           (src2),
    .result_valid   (result_valid),
    .npc            (npc),
    .wdata          (wdata),
    .rd             (rd),
    .rd_write       (rd_write),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache)
  );

  // ####################
  // instruction encoding
  // ####################

  function automatic word_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                   input int rd_idx);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd_idx[4:0], OPC_OP};
  endfunction

  function automatic word_t i_type(input int imm, input int rs1, input int f3, input int rd_idx,
                                   input opcode_t opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd_idx[4:0], opc};
  endfunction

  function automatic word_t u_type(input int imm, input int rd_idx, input opcode_t opc);
    return {imm[19:0], rd_idx[4:0], opc};
  endfunction

  function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t j_type(input int imm, input int rd_idx);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd_idx[4:0], OPC_JAL};
  endfunction

  function automatic logic has_flag(input logic [7:0] flags, input logic [7:0] mask);
    return (flags & mask) != 8'h00;
  endfunction

  // opcodes with a destination register.
  function automatic logic writes_reg(input word_t i);
    return i[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};
  endfunction

  // ####################
  // table
  // ####################

  task automatic add_row(input word_t i, input word_t p, input word_t s1, input word_t s2,
                         input logic [7:0] flags, input word_t exp_npc, input word_t exp_wdata);
    row_t r;
    r = '{i, p, s1, s2, flags, exp_npc, exp_wdata, cur_group};
    rows.push_back(r);
  endtask

  task automatic build_table();
    cur_group = 1;
    add_row(r_type('h00, 2, 1, 0, 10), 32'h100, 32'h7, 32'h5, RUN, 32'h104, 32'hc);
    add_row(r_type('h20, 2, 1, 0, 11), 32'h104, 32'h5, 32'h7, RUN, 32'h108, 32'hfffffffe);
    add_row(r_type('h00, 2, 1, 1, 12), 32'h108, 32'h3, 32'h24, RUN, 32'h10c, 32'h30);
    add_row(r_type('h20, 2, 1, 5, 13), 32'h10c, 32'h80000000, 32'h4, RUN, 32'h110, 32'hf8000000);
    add_row(r_type('h00, 2, 1, 5, 14), 32'h110, 32'h80000000, 32'h4, RUN, 32'h114, 32'h08000000);
    add_row(r_type('h00, 2, 1, 2, 15), 32'h114, 32'hffffffff, 32'h1, RUN, 32'h118, 32'h1);
    add_row(r_type('h00, 2, 1, 3, 10), 32'h118, 32'hffffffff, 32'h1, RUN, 32'h11c, 32'h0);
    add_row(i_type('h0ff, 1, 4, 11, OPC_OP_IMM), 32'h11c, 32'h0f0f, 0, RUN | RND2, 32'h120, 32'h0ff0);
    add_row(i_type('h800, 1, 6, 12, OPC_OP_IMM), 32'h120, 32'h12, 0, RUN | RND2, 32'h124, 32'hfffff812);
    add_row(i_type('h0f0, 1, 7, 13, OPC_OP_IMM), 32'h124, 32'habcd, 0, RUN | RND2, 32'h128, 32'hc0);
    add_row(i_type('h408, 1, 5, 14, OPC_OP_IMM), 32'h128, 32'h80000010, 0, RUN | RND2, 32'h12c,
            32'hff800000);
    add_row(u_type('h12345, 15, OPC_LUI), 32'h12c, 0, 0, RUN | RNDS, 32'h130, 32'h12345000);
    add_row(u_type('h1, 10, OPC_AUIPC), 32'h130, 0, 0, RUN | RNDS, 32'h134, 32'h1130);
    cur_group = 2;  // every redirect is followed by a slot that must vanish.
    add_row(b_type(16, 2, 1, 0), 32'h200, 32'h5, 32'h5, RUN | EXP_CLR, 32'h210, 32'h1);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h204, 32'h1, 32'h1, VLD, 0, 0);
    add_row(b_type(16, 2, 1, 1), 32'h210, 32'h5, 32'h5, RUN, 32'h214, 32'h0);
    add_row(b_type(-8, 2, 1, 4), 32'h214, 32'hffffffff, 32'h1, RUN | EXP_CLR, 32'h20c, 32'h1);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h218, 32'h1, 32'h1, VLD, 0, 0);
    add_row(b_type(8, 2, 1, 5), 32'h20c, 32'hffffffff, 32'h1, RUN, 32'h210, 32'h0);
    add_row(b_type(8, 2, 1, 7), 32'h210, 32'h1, 32'hffffffff, RUN, 32'h214, 32'h0);
    add_row(b_type('h20, 2, 1, 6), 32'h214, 32'h1, 32'h2, RUN | EXP_CLR, 32'h234, 32'h1);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h218, 32'h1, 32'h1, VLD, 0, 0);
    add_row(j_type('h100, 3), 32'h300, 0, 0, RUN | EXP_CLR | RNDS, 32'h400, 32'h304);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h304, 32'h1, 32'h1, VLD, 0, 0);
    add_row(i_type('h11, 5, 0, 4, OPC_JALR), 32'h400, 32'h1000, 0, RUN | EXP_CLR | RND2, 32'h1010,
            32'h404);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h404, 32'h1, 32'h1, VLD, 0, 0);
    cur_group = 3;  // filler sources show that the previous wdata was used.
    add_row(i_type('h10, 7, 0, 6, OPC_OP_IMM), 32'h500, 32'h100, 0, RUN | RND2, 32'h504, 32'h110);
    add_row(r_type('h00, 6, 6, 0, 8), 32'h504, 0, 0, RUN | RNDS, 32'h508, 32'h220);
    add_row(r_type('h20, 1, 8, 0, 9), 32'h508, 0, 32'h20, RUN | RND1, 32'h50c, 32'h200);
    add_row(i_type(5, 9, 0, 0, OPC_OP_IMM), 32'h50c, 0, 0, RUN | RNDS, 32'h510, 32'h205);
    add_row(r_type('h00, 2, 0, 0, 10), 32'h510, 32'h0, 32'h3, RUN, 32'h514, 32'h3);
    cur_group = 4;
    add_row(i_type(1, 1, 0, 11, OPC_OP_IMM), 32'h600, 32'h41, 0, RUN | RND2, 32'h604, 32'h42);
    add_row(i_type(2, 2, 0, 12, OPC_OP_IMM), 32'h604, 32'h50, 0, RUN | BLK | RND2, 32'h604, 32'h42);
    add_row(i_type(2, 2, 0, 12, OPC_OP_IMM), 32'h604, 32'h50, 0, RUN | BLK | RND2, 32'h604, 32'h42);
    add_row(i_type(2, 2, 0, 12, OPC_OP_IMM), 32'h604, 32'h50, 0, RUN | RND2, 32'h608, 32'h52);
    cur_group = 5;
    add_row(i_type(0, 0, 1, 0, OPC_MISC_MEM), 32'h700, 0, 0,
            RUN | RNDS | EXP_CLR | EXP_CC | SKIP_W, 32'h704, 0);
    add_row(r_type('h00, 2, 1, 0, 10), 32'h704, 32'h1, 32'h1, VLD, 0, 0);
    add_row(32'h0, 32'h708, 0, 0, 8'h00, 0, 0);
  endtask

  // ####################
  // drive and check
  // ####################

  task automatic drive_row(input row_t r);
    instr       = r.instr;
    pc          = r.pc;
    src1        = has_flag(r.flags, RND1) ? $urandom : r.src1;
    src2        = has_flag(r.flags, RND2) ? $urandom : r.src2;
    instr_valid = has_flag(r.flags, VLD);
    block       = has_flag(r.flags, BLK);
  endtask

  task automatic compare(input string name, input word_t got, input word_t expected);
    group_checks++;
    total_checks++;
    assert (got === expected) else begin
      $display("[ERROR] %s got %h expected %h", name, got, expected);
      group_errors++;
      total_errors++;
    end
  endtask

  task automatic check_row(input row_t r, input word_t res_instr);
    logic exp_write;
    exp_write = has_flag(r.flags, EXP_V) && writes_reg(res_instr);
    compare("result_valid", word_t'(result_valid), word_t'(has_flag(r.flags, EXP_V)));
    compare("clear_pipeline", word_t'(clear_pipeline), word_t'(has_flag(r.flags, EXP_CLR)));
    compare("clear_cache", word_t'(clear_cache), word_t'(has_flag(r.flags, EXP_CC)));
    compare("rd_write", word_t'(rd_write), word_t'(exp_write));
    if (has_flag(r.flags, EXP_V)) begin
      compare("npc", npc, r.npc);
      if (!has_flag(r.flags, SKIP_W)) begin
        compare("wdata", wdata, r.wdata);
      end
    end
    if (exp_write) begin
      compare("rd", word_t'(rd), word_t'(res_instr[11:7]));
    end
  endtask

  task automatic report_group(input int g);
    $display("group %s: %0d checks, %0d errors", group_name[g], group_checks, group_errors);
    group_checks = 0;
    group_errors = 0;
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    block       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    src1        = '0;
    src2        = '0;
    shown_instr = '0;
    build_table();
    cycle_limit = rows.size() + 20;
    @(negedge reset);
    compare("result_valid", word_t'(result_valid), 0);
    compare("clear_pipeline", word_t'(clear_pipeline), 0);
    compare("clear_cache", word_t'(clear_cache), 0);
    compare("rd_write", word_t'(rd_write), 0);
    report_group(0);
    drive_row(rows[0]);
    for (int i = 1; i <= rows.size(); i++) begin
      @(posedge clock);
      #1;
      if (has_flag(rows[i - 1].flags, EXP_V) && !has_flag(rows[i - 1].flags, BLK)) begin
        shown_instr = rows[i - 1].instr;
      end
      check_row(rows[i - 1], shown_instr);  // outputs come from registers only.
      if (i == rows.size()) begin
        report_group(rows[i - 1].group);
        drive_row('0);
      end else begin
        if (rows[i].group != rows[i - 1].group) begin
          report_group(rows[i - 1].group);
        end
        drive_row(rows[i]);
      end
    end
    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
src/rv_types_pkg.sv
src/rv_stage_pkg.sv
src/int_alu.sv
src/instr_decoder.sv
src/execute_stage.sv
src/result_select.sv
src/exec_top.sv
tb/clock_gen.sv
tb/exec_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_top_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
